/* debug_port.f */
source/debug_pkg.sv
source/cmd_decoder.sv
source/resp_fifo.sv
source/resp_serializer.sv
source/debug_port.sv
verif/debug_port_chk.sv
verif/debug_port_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the debug port testbench with Verilator and runs it.
# The run counts as passed only if the pass line shows up in its output.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module debug_port_tb \
    -f debug_port.f

sim_out=$(./obj_dir/Vdebug_port_tb 2>&1 || true)
echo "$sim_out"

if echo "$sim_out" | grep -q "^TB PASSED$"; then
    exit 0
fi
exit 1

/* verif/debug_port_tb.sv */
/*
  Testbench for the debug command port.
  Sends commands with random status and arguments, predicts each
  response with a reference model and compares every serialized byte
  in command order. Also checks cfg, busy and first-byte latency.
*/
`timescale 1ns/1ps

module debug_port_tb;

    localparam int clk_half    = 20;
    localparam int busy_limit  = 200;   // Cycles
    localparam int drain_limit = 2000;
    localparam int run_limit   = 40000;

    typedef logic [7:0] byte_q_t [$];

    logic               clk;
    logic               rst_n;
    logic [7:0]         debug_cmd;
    logic [7:0]         debug_arg;
    logic               debug_cmd_valid;
    debug_pkg::status_t status;
    logic               cmd_busy;
    logic [7:0]         debug_resp;
    logic               debug_resp_valid;
    debug_pkg::cfg_t    cfg;

    logic [7:0]      expected_q [$];  // Scoreboard, oldest byte first
    debug_pkg::cfg_t cfg_model;
    logic            busy_seen;

    debug_port u_debug_port (
        .clk              (clk),
        .rst_n            (rst_n),
        .debug_cmd        (debug_cmd),
        .debug_arg        (debug_arg),
        .debug_cmd_valid  (debug_cmd_valid),
        .status           (status),
        .cmd_busy         (cmd_busy),
        .debug_resp       (debug_resp),
        .debug_resp_valid (debug_resp_valid),
        .cfg              (cfg)
    );

    initial begin
        clk = 1'b0;
        forever #clk_half clk = ~clk;
    end

    ////////////////////////////////////////
    // Reporting
    ////////////////////////////////////////
    task automatic check_val(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("TB FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        $display("ERROR at %0t ns: %s", $time, why);
        $display("TB FAILED");
        $fatal(1, "run aborted");
    endtask

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////
    function automatic byte_q_t expected_resp(input logic [7:0] cmd, input logic [7:0] arg,
                                              input debug_pkg::status_t st);
        byte_q_t q;
        case (cmd)
            debug_pkg::cmd_nop: q.push_back(8'h00);
            debug_pkg::cmd_get_status: begin
                q.push_back(cmd);
                q.push_back({4'h0, st.proxy_active, st.host_connected,
                             st.device_connected, 1'b0});
                q.push_back({4'h0, st.host_speed, st.device_speed});
                q.push_back({7'h00, st.buffer_overflow});
            end
            debug_pkg::cmd_get_buffer_status: q = '{cmd, st.buffer_used[7:0],
                                                     st.buffer_used[15:8]};
            debug_pkg::cmd_get_packet_count: begin
                q.push_back(cmd);
                for (int i = 0; i < 4; i++) q.push_back(st.packet_count[8*i +: 8]);
            end
            debug_pkg::cmd_get_error_count: q = '{cmd, st.error_count[7:0],
                                                   st.error_count[15:8]};
            debug_pkg::cmd_get_line_state:
                q = '{cmd, {4'h0, st.device_line_state, st.host_line_state}};
            debug_pkg::cmd_set_leds:     q = '{cmd, arg};
            debug_pkg::cmd_set_mode:     q = '{cmd, {6'h00, arg[1:0]}};
            debug_pkg::cmd_set_loopback: q = '{cmd, {7'h00, arg[0]}};
            debug_pkg::cmd_version: q = '{cmd, debug_pkg::version_major,
                                          debug_pkg::version_minor, debug_pkg::version_patch};
            default: q = '{debug_pkg::resp_error, cmd};  // Unknown, code echoed
        endcase
        return q;
    endfunction

    function automatic debug_pkg::cfg_t next_cfg(input debug_pkg::cfg_t cur,
                                                 input logic [7:0] cmd, input logic [7:0] arg);
        debug_pkg::cfg_t nxt;
        nxt = cur;
        if (cmd == debug_pkg::cmd_set_leds) nxt.leds = arg;
        else if (cmd == debug_pkg::cmd_set_mode) nxt.mode = arg[1:0];
        else if (cmd == debug_pkg::cmd_set_loopback) nxt.loopback = arg[0];
        return nxt;
    endfunction

    // 0 to 5 are the reads, 6 to 8 the sets, 9 the version
    function automatic logic [7:0] known_code(input int unsigned idx);
        case (idx)
            0:       return debug_pkg::cmd_nop;
            1:       return debug_pkg::cmd_get_status;
            2:       return debug_pkg::cmd_get_buffer_status;
            3:       return debug_pkg::cmd_get_packet_count;
            4:       return debug_pkg::cmd_get_error_count;
            5:       return debug_pkg::cmd_get_line_state;
            6:       return debug_pkg::cmd_set_leds;
            7:       return debug_pkg::cmd_set_mode;
            8:       return debug_pkg::cmd_set_loopback;
            default: return debug_pkg::cmd_version;
        endcase
    endfunction

    function automatic debug_pkg::status_t random_status();
        logic [63:0] raw;
        raw = {$urandom(), $urandom()};
        return debug_pkg::status_t'(raw[60:0]);
    endfunction

    ////////////////////////////////////////
    // Driver, entered 2 ns after a rising edge
    ////////////////////////////////////////
    task automatic wait_not_busy();
        int cycles;
        cycles = 0;
        while (cmd_busy) begin
            busy_seen = 1'b1;
            if (cycles >= busy_limit) begin
                abort_run("cmd_busy stayed high too long");
            end else begin
                @(posedge clk);
                #2;
                cycles++;
            end
        end
    endtask

    task automatic send_cmd(input logic [7:0] cmd, input logic [7:0] arg);
        byte_q_t exp;
        wait_not_busy();
        status          = random_status();
        debug_cmd       = cmd;
        debug_arg       = arg;
        debug_cmd_valid = 1'b1;
        exp = expected_resp(cmd, arg, status);
        foreach (exp[i]) expected_q.push_back(exp[i]);
        cfg_model = next_cfg(cfg_model, cmd, arg);
        @(posedge clk);  // Sampling edge
        #2;
        debug_cmd_valid = 1'b0;
        check_val("cfg", 32'(cfg), 32'(cfg_model));
    endtask

    task automatic drain_scoreboard();
        int cycles;
        cycles = 0;
        while (expected_q.size() != 0) begin
            if (cycles >= drain_limit) begin
                abort_run("expected response bytes never arrived");
            end else begin
                @(posedge clk);
                #2;
                cycles++;
            end
        end
    endtask

    // Compare outputs mid-cycle where they are stable
    initial begin : compare_bytes
        logic [7:0] exp_byte;
        forever begin
            @(negedge clk);
            if (rst_n && debug_resp_valid) begin
                if (expected_q.size() == 0) begin
                    abort_run("response byte arrived with none expected");
                end else begin
                    exp_byte = expected_q.pop_front();
                    check_val("debug_resp", 32'(debug_resp), 32'(exp_byte));
                end
            end
        end
    end

    initial begin : watchdog
        for (int i = 0; i < run_limit; i++) @(posedge clk);
        abort_run("simulation ran past its cycle limit");
    end

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////
    initial begin : main_seq
        int unsigned pick;
        logic [7:0]  code;
        void'($urandom(32'h969b));
        rst_n           = 1'b1;
        debug_cmd       = 8'h00;
        debug_arg       = 8'h00;
        debug_cmd_valid = 1'b0;
        status          = '0;
        cfg_model       = '0;
        busy_seen       = 1'b0;
        #2;
        rst_n = 1'b0;
        repeat (16) @(posedge clk);
        #2;
        check_val("debug_resp_valid", 32'(debug_resp_valid), 32'd0);
        check_val("debug_resp", 32'(debug_resp), 32'd0);
        check_val("cmd_busy", 32'(cmd_busy), 32'd0);
        check_val("cfg", 32'(cfg), 32'd0);
        rst_n = 1'b1;
        @(posedge clk);
        #2;

        // Idle pipeline gives the first byte two edges after sampling
        send_cmd(debug_pkg::cmd_nop, 8'h00);
        @(negedge clk);
        check_val("debug_resp_valid", 32'(debug_resp_valid), 32'd0);
        @(negedge clk);
        check_val("debug_resp_valid", 32'(debug_resp_valid), 32'd0);
        @(negedge clk);
        check_val("debug_resp_valid", 32'(debug_resp_valid), 32'd1);
        @(posedge clk);
        #2;

        for (int unsigned i = 0; i < 9; i++) begin  // Reads then sets
            repeat (5) send_cmd(known_code(i), 8'($urandom()));
        end

        send_cmd(debug_pkg::cmd_version, 8'($urandom()));
        send_cmd(8'h06, 8'($urandom()));  // Codes of dropped functions
        send_cmd(8'h11, 8'($urandom()));
        send_cmd(8'h20, 8'($urandom()));
        send_cmd(8'h22, 8'($urandom()));
        repeat (6) send_cmd(8'(32'h30 + $urandom_range(0, 32'hBF)), 8'($urandom()));

        // Back-to-back burst must fill the FIFO
        drain_scoreboard();
        busy_seen = 1'b0;
        repeat (10) send_cmd(debug_pkg::cmd_get_packet_count, 8'h00);
        check_val("busy_seen", 32'(busy_seen), 32'd1);

        repeat (300) begin
            pick = $urandom_range(0, 11);
            code = (pick >= 10) ? 8'($urandom()) : known_code(pick);
            send_cmd(code, 8'($urandom()));
        end

        drain_scoreboard();
        repeat (4) @(posedge clk);
        if (u_debug_port.u_debug_port_chk.reset_fails +
            u_debug_port.u_debug_port_chk.overflow_fails +
            u_debug_port.u_debug_port_chk.latency_fails != 0) begin
            abort_run("an assertion in the bound checker failed");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

/* verif/debug_port_chk.sv */
/*
  Assertions for the debug port, bound into debug_port.
  Covers reset values, writes into a full response FIFO and the
  time from an accepted strobe to response activity.
  Per-assertion failure counts are readable by the testbench.
*/
`timescale 1ns/1ps

module debug_port_chk (
    input logic            clk,
    input logic            rst_n,
    input logic            debug_cmd_valid,
    input logic            cmd_busy,
    input logic            wr_en,
    input logic            rd_en,
    input logic            debug_resp_valid,
    input debug_pkg::cfg_t cfg
);

    localparam int resp_timeout = 30;  // Cycles

    int unsigned reset_fails    = 0;
    int unsigned overflow_fails = 0;
    int unsigned latency_fails  = 0;

    logic                 accepted;
    logic                 waiting;
    logic [5:0]           wait_cnt;
    logic                 pop;
    debug_pkg::fifo_cnt_t occ;  // Records held, counted from pushes and pops

    assign accepted = debug_cmd_valid && !cmd_busy;
    assign pop      = rd_en && (occ != '0);

    // Age of the oldest strobe not yet followed by a response byte
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            waiting  <= 1'b0;
            wait_cnt <= 6'd0;
        end else if (accepted && (!waiting || debug_resp_valid)) begin
            waiting  <= 1'b1;
            wait_cnt <= 6'd0;
        end else if (debug_resp_valid) begin
            waiting  <= 1'b0;
            wait_cnt <= 6'd0;
        end else if (waiting) begin
            wait_cnt <= wait_cnt + 6'd1;
        end
    end

    // Own occupancy model of the response FIFO
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            occ <= '0;
        end else if (wr_en && !pop) begin
            occ <= occ + debug_pkg::fifo_cnt_t'(1);
        end else if (pop && !wr_en) begin
            occ <= occ - debug_pkg::fifo_cnt_t'(1);
        end
    end

    a_reset_quiet: assert property (@(posedge clk)
        !rst_n |-> (!debug_resp_valid && cfg == '0))
        else begin
            reset_fails++;
            $error("response valid or cfg not cleared during reset");
        end

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> (occ < debug_pkg::fifo_cnt_t'(debug_pkg::fifo_depth)))
        else begin
            overflow_fails++;
            $error("response FIFO written while full");
        end

    a_resp_latency: assert property (@(posedge clk) disable iff (!rst_n)
        waiting |-> (wait_cnt < 6'(resp_timeout)))
        else begin
            latency_fails++;
            $error("no response byte within %0d cycles of a command", resp_timeout);
        end

endmodule

bind debug_port debug_port_chk u_debug_port_chk (
    .clk              (clk),
    .rst_n            (rst_n),
    .debug_cmd_valid  (debug_cmd_valid),
    .cmd_busy         (cmd_busy),
    .wr_en            (wr_en),
    .rd_en            (rd_en),
    .debug_resp_valid (debug_resp_valid),
    .cfg              (cfg)
);

/* source/debug_port.sv */
/*
  Debug command port of the USB sniffer.
  A command byte and its argument, strobed by debug_cmd_valid, are
  decoded into a response record, queued in a small FIFO and sent
  back one byte per clock on debug_resp.
  Do not strobe while cmd_busy is high, such a command is dropped.
*/
`timescale 1ns/1ps

module debug_port (
    input  logic               clk,
    input  logic               rst_n,

    // Command side
    input  logic [7:0]         debug_cmd,
    input  logic [7:0]         debug_arg,
    input  logic               debug_cmd_valid,
    input  debug_pkg::status_t status,       // Sampled with the strobe
    output logic               cmd_busy,     // Response FIFO full

    // Response side
    output logic [7:0]         debug_resp,
    output logic               debug_resp_valid,

    output debug_pkg::cfg_t    cfg
);

    ////////////////////////////////////////
    // Stage wiring
    ////////////////////////////////////////
    logic             wr_en;
    debug_pkg::resp_t wr_rec;
    logic             rd_en;
    debug_pkg::resp_t rd_rec;
    logic             empty;

    cmd_decoder u_cmd_decoder (
        .clk             (clk),
        .rst_n           (rst_n),
        .debug_cmd       (debug_cmd),
        .debug_arg       (debug_arg),
        .debug_cmd_valid (debug_cmd_valid),
        .status          (status),
        .full            (cmd_busy),
        .wr_en           (wr_en),
        .wr_rec          (wr_rec),
        .cfg             (cfg)
    );

    // Full flag doubles as the busy level seen outside
    resp_fifo u_resp_fifo (
        .clk    (clk),
        .rst_n  (rst_n),
        .wr_en  (wr_en),
        .wr_rec (wr_rec),
        .rd_en  (rd_en),
        .rd_rec (rd_rec),
        .full   (cmd_busy),
        .empty  (empty)
    );

    resp_serializer u_resp_serializer (
        .clk              (clk),
        .rst_n            (rst_n),
        .rd_rec           (rd_rec),
        .empty            (empty),
        .rd_en            (rd_en),
        .debug_resp       (debug_resp),
        .debug_resp_valid (debug_resp_valid)
    );

endmodule

/* source/resp_serializer.sv */
/*
  Response serializer of the debug port.
  Pops one record at a time from the response FIFO and drives its
  bytes on debug_resp, byte 0 first, one per clock with
  debug_resp_valid. Records are never interleaved and the next pop
  happens on the edge after the last byte.
*/
`timescale 1ns/1ps

module resp_serializer (
    input  logic              clk,
    input  logic              rst_n,
    input  debug_pkg::resp_t  rd_rec,
    input  logic              empty,
    output logic              rd_en,
    output logic [7:0]        debug_resp,
    output logic              debug_resp_valid
);

    debug_pkg::resp_data_t shift_q;  // Bytes still to go, next one at index 0
    debug_pkg::len_t       remain_q;
    logic                  idle;

    assign idle  = (remain_q == '0);
    assign rd_en = idle && !empty;   // Pop only between records

    ////////////////////////////////////////
    // Control and output byte
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            remain_q         <= '0;
            debug_resp       <= 8'h00;
            debug_resp_valid <= 1'b0;
        end else if (!idle) begin
            debug_resp       <= shift_q[0];
            debug_resp_valid <= 1'b1;
            remain_q         <= remain_q - debug_pkg::len_t'(1);
        end else begin
            debug_resp_valid <= 1'b0;      // Last byte keeps showing, not valid
            if (rd_en) begin
                remain_q <= rd_rec.len;
            end
        end
    end

    // Payload shift register
    always_ff @(posedge clk) begin
        if (rd_en) begin
            shift_q <= rd_rec.data;
        end else if (!idle) begin
            shift_q <= shift_q >> 8;        // Next byte down to index 0
        end
    end

endmodule

/* source/resp_fifo.sv */
/*
  Response FIFO of the debug port.
  A ring of whole response records between decoder and serializer.
  The head record shows on rd_rec without a register, so a write
  appears there one edge later. Write and read may share an edge.
*/
`timescale 1ns/1ps

module resp_fifo (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             wr_en,
    input  debug_pkg::resp_t wr_rec,
    input  logic             rd_en,
    output debug_pkg::resp_t rd_rec,
    output logic             full,
    output logic             empty
);

    debug_pkg::resp_t     mem [debug_pkg::fifo_depth];
    debug_pkg::fifo_ptr_t wr_ptr;
    debug_pkg::fifo_ptr_t rd_ptr;
    debug_pkg::fifo_cnt_t count;   // Records held
    logic                 do_wr;
    logic                 do_rd;

    assign full  = (count == debug_pkg::fifo_cnt_t'(debug_pkg::fifo_depth));
    assign empty = (count == '0);
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    assign rd_rec = mem[rd_ptr];  // Head record

    // Storage
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_rec;
        end
    end

    // Pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) wr_ptr <= wr_ptr + debug_pkg::fifo_ptr_t'(1);
            if (do_rd) rd_ptr <= rd_ptr + debug_pkg::fifo_ptr_t'(1);
            case ({do_wr, do_rd})
                2'b10:   count <= count + debug_pkg::fifo_cnt_t'(1);
                2'b01:   count <= count - debug_pkg::fifo_cnt_t'(1);
                default: count <= count;  // Both or neither
            endcase
        end
    end

endmodule

/* source/cmd_decoder.sv */
/*
  Command decoder of the debug port.
  Turns an accepted command strobe into a whole response record,
  written to the response FIFO on the sampling edge, and keeps the
  LED, mode and loopback configuration registers.
  A strobe is accepted only while the FIFO has room.
*/
`timescale 1ns/1ps

module cmd_decoder (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [7:0]         debug_cmd,
    input  logic [7:0]         debug_arg,
    input  logic               debug_cmd_valid,
    input  debug_pkg::status_t status,
    input  logic               full,
    output logic               wr_en,
    output debug_pkg::resp_t   wr_rec,
    output debug_pkg::cfg_t    cfg
);

    logic accept;

    assign accept = debug_cmd_valid && !full;  // Busy strobes vanish
    assign wr_en  = accept;

    ////////////////////////////////////////
    // Response record
    ////////////////////////////////////////
    always_comb begin
        wr_rec = '0;  // Unused bytes stay zero
        case (debug_cmd)
            debug_pkg::cmd_nop: begin
                wr_rec.len     = debug_pkg::len_t'(1);
                wr_rec.data[0] = debug_pkg::cmd_nop;
            end
            debug_pkg::cmd_get_status: begin
                wr_rec.len     = debug_pkg::len_t'(4);
                wr_rec.data[0] = debug_pkg::cmd_get_status;
                wr_rec.data[1] = {4'b0000, status.proxy_active, status.host_connected,
                                  status.device_connected, 1'b0};
                wr_rec.data[2] = {4'b0000, status.host_speed, status.device_speed};
                wr_rec.data[3] = {7'b0000000, status.buffer_overflow};
            end
            debug_pkg::cmd_get_buffer_status: begin
                wr_rec.len     = debug_pkg::len_t'(3);
                wr_rec.data[0] = debug_pkg::cmd_get_buffer_status;
                wr_rec.data[1] = status.buffer_used[7:0];   // Low byte first
                wr_rec.data[2] = status.buffer_used[15:8];
            end
            debug_pkg::cmd_get_packet_count: begin
                wr_rec.len     = debug_pkg::len_t'(5);
                wr_rec.data[0] = debug_pkg::cmd_get_packet_count;
                wr_rec.data[1] = status.packet_count[7:0];
                wr_rec.data[2] = status.packet_count[15:8];
                wr_rec.data[3] = status.packet_count[23:16];
                wr_rec.data[4] = status.packet_count[31:24];
            end
            debug_pkg::cmd_get_error_count: begin
                wr_rec.len     = debug_pkg::len_t'(3);
                wr_rec.data[0] = debug_pkg::cmd_get_error_count;
                wr_rec.data[1] = status.error_count[7:0];
                wr_rec.data[2] = status.error_count[15:8];
            end
            debug_pkg::cmd_get_line_state: begin
                wr_rec.len     = debug_pkg::len_t'(2);
                wr_rec.data[0] = debug_pkg::cmd_get_line_state;
                wr_rec.data[1] = {4'b0000, status.device_line_state,
                                  status.host_line_state};
            end
            debug_pkg::cmd_set_leds: begin
                wr_rec.len     = debug_pkg::len_t'(2);
                wr_rec.data[0] = debug_pkg::cmd_set_leds;
                wr_rec.data[1] = debug_arg;                      // Echo of new value
            end
            debug_pkg::cmd_set_mode: begin
                wr_rec.len     = debug_pkg::len_t'(2);
                wr_rec.data[0] = debug_pkg::cmd_set_mode;
                wr_rec.data[1] = {6'b000000, debug_arg[1:0]};
            end
            debug_pkg::cmd_set_loopback: begin
                wr_rec.len     = debug_pkg::len_t'(2);
                wr_rec.data[0] = debug_pkg::cmd_set_loopback;
                wr_rec.data[1] = {7'b0000000, debug_arg[0]};
            end
            debug_pkg::cmd_version: begin
                wr_rec.len     = debug_pkg::len_t'(4);
                wr_rec.data[0] = debug_pkg::cmd_version;
                wr_rec.data[1] = debug_pkg::version_major;
                wr_rec.data[2] = debug_pkg::version_minor;
                wr_rec.data[3] = debug_pkg::version_patch;
            end
            default: begin
                // Unknown code is echoed behind the error marker
                wr_rec.len     = debug_pkg::len_t'(2);
                wr_rec.data[0] = debug_pkg::resp_error;
                wr_rec.data[1] = debug_cmd;
            end
        endcase
    end

    ////////////////////////////////////////
    // Configuration registers
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg <= '0;
        end else if (accept) begin
            case (debug_cmd)
                debug_pkg::cmd_set_leds:     cfg.leds     <= debug_arg;
                debug_pkg::cmd_set_mode:     cfg.mode     <= debug_arg[1:0];
                debug_pkg::cmd_set_loopback: cfg.loopback <= debug_arg[0];
                default:                     cfg          <= cfg;  // Reads leave it alone
            endcase
        end
    end

endmodule

/* source/debug_pkg.sv */
/*
  Shared definitions for the debug command port pipeline.
  Holds the command codes, version bytes, buffer sizes and the
  record, status and configuration structs passed between the
  decoder, the response FIFO and the serializer.
  Stages reference it by scoped name.
*/
package debug_pkg;

    ////////////////////////////////////////
    // Command codes
    ////////////////////////////////////////
    localparam logic [7:0] cmd_nop               = 8'h00;
    localparam logic [7:0] cmd_get_status        = 8'h01;
    localparam logic [7:0] cmd_get_buffer_status = 8'h02;
    localparam logic [7:0] cmd_get_packet_count  = 8'h03;
    localparam logic [7:0] cmd_get_error_count   = 8'h04;
    localparam logic [7:0] cmd_get_line_state    = 8'h05;
    localparam logic [7:0] cmd_set_leds          = 8'h10;
    localparam logic [7:0] cmd_set_mode          = 8'h12;
    localparam logic [7:0] cmd_set_loopback      = 8'h21;
    localparam logic [7:0] cmd_version           = 8'hF0;

    localparam logic [7:0] resp_error = 8'hFF; // Leads the reply to an unknown code

    localparam logic [7:0] version_major = 8'h01;
    localparam logic [7:0] version_minor = 8'h00;
    localparam logic [7:0] version_patch = 8'h00;

    ////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////
    localparam int resp_max_bytes = 5;  // Packet count reply is the longest
    localparam int resp_len_w     = 3;
    localparam int fifo_depth     = 4;  // Records, not bytes
    localparam int fifo_ptr_w     = 2;

    typedef logic [resp_len_w-1:0]           len_t;
    typedef logic [resp_max_bytes-1:0][7:0] resp_data_t;  // Index 0 leaves first
    typedef logic [fifo_ptr_w-1:0]           fifo_ptr_t;
    typedef logic [fifo_ptr_w:0]             fifo_cnt_t;   // One extra bit for full

    ////////////////////////////////////////
    // Structs
    ////////////////////////////////////////
    typedef struct packed {
        logic        proxy_active;
        logic        host_connected;
        logic        device_connected;
        logic        buffer_overflow;
        logic [1:0]  host_speed;
        logic [1:0]  device_speed;
        logic [1:0]  host_line_state;
        logic [1:0]  device_line_state;
        logic [15:0] buffer_used;
        logic [31:0] packet_count;
        logic [15:0] error_count;
    } status_t;

    // One complete response, as built by the decoder
    typedef struct packed {
        len_t       len;
        resp_data_t data;
    } resp_t;

    typedef struct packed {
        logic [7:0] leds;
        logic [1:0] mode;
        logic       loopback;
    } cfg_t;

endpackage
